// File: project.f
+incdir+.
cpu_pkg.sv
page_mmu.sv
wb_mem_master.sv
cpu_sequencer.sv
cpu_top.sv
tb_wb_memory.sv
tb_cpu.sv

// File: Bender.yml
package:
  name: paged_cpu

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - page_mmu.sv
      - wb_mem_master.sv
      - cpu_sequencer.sv
      - cpu_top.sv
      - target: test
        files:
          - tb_wb_memory.sv
          - tb_cpu.sv

// File: tb_cpu.sv
`include "cpu_macros.svh"

module tb_cpu;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS  = 6;
  localparam int HALT_LIMIT = 2000;  // cycles allowed per program

  logic             clka;
  logic             rst;
  logic             halted;
  logic             fault;
  cpu_pkg::wb_m2s_t bus_o;
  cpu_pkg::wb_s2m_t bus_i;

  int                      prog_ptr;
  logic [`CPU_PADDR_W-1:0] exp_adr [$];
  logic [`CPU_DATA_W-1:0]  exp_dat [$];

  cpu_top UUT (.clka, .rst, .bus_o, .bus_i, .halted, .fault);

  tb_wb_memory memory (.clka(clka), .m2s(bus_o), .s2m(bus_i));

  always #4 clka = ~clka;

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else
      stop_with_failure($sformatf("Error at %0d ns: %s expected 0x%0h, actual 0x%0h",
                                  $time, name, exp, act));
  endtask

  // two-word instruction at the program pointer
  task automatic emit(cpu_pkg::opcode_e op, logic [7:0] rsel, logic [15:0] val);
    memory.mem[prog_ptr]     = {op, rsel};
    memory.mem[prog_ptr + 1] = val;
    prog_ptr += 2;
  endtask

  task automatic expect_write(logic [`CPU_PADDR_W-1:0] adr, logic [`CPU_DATA_W-1:0] dat);
    exp_adr.push_back(adr);
    exp_dat.push_back(dat);
  endtask

  task automatic begin_program();
    @(negedge clka);
    rst = 1'b0;
    memory.reset_contents();
    prog_ptr = 0;
    exp_adr.delete();
    exp_dat.delete();
  endtask

  task automatic run_program();
    int cycles;
    repeat (10) begin
      @(negedge clka);
      assert (!bus_o.cyc && !bus_o.stb && !bus_o.we && !halted && !fault) else
        stop_with_failure("bus or status output high during reset");
    end
    rst = 1'b1;
    cycles = 0;
    while (!halted && cycles < HALT_LIMIT) begin
      @(negedge clka);
      cycles++;
    end
    assert (halted) else stop_with_failure("halted did not rise within the cycle limit");
  endtask

  task automatic check_writes();
    check_value("write count", exp_adr.size(), memory.log_adr.size());
    foreach (exp_adr[i]) begin
      check_value($sformatf("write adr [%0d]", i), exp_adr[i], memory.log_adr[i]);
      check_value($sformatf("write dat [%0d]", i), exp_dat[i], memory.log_dat[i]);
    end
  endtask

  task automatic basic_store_and_halt();
    logic [15:0] v;
    v = 16'($urandom);
    begin_program();
    emit(cpu_pkg::NUM2REG, 8'h13, v);  // upper nibble ignored, r3
    emit(cpu_pkg::REG2RAM, 8'h03, 16'd40);
    emit(cpu_pkg::HALT, 8'h00, 16'h0000);
    expect_write(10'd40, v);
    run_program();
    check_writes();
    check_value("fault", 0, fault);
  endtask

  task automatic wrapped_arithmetic();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
    a = 16'($urandom);
    b = 16'($urandom);
    c = 16'($urandom);
    begin_program();
    emit(cpu_pkg::NUM2REG, 8'h04, a);
    emit(cpu_pkg::REG_PLUS, 8'h04, b);
    emit(cpu_pkg::REG2RAM, 8'h04, 16'd48);
    emit(cpu_pkg::NUM2REG, 8'h05, a);
    emit(cpu_pkg::REG_MINUS, 8'h05, c);
    emit(cpu_pkg::REG2RAM, 8'h05, 16'd49);
    emit(cpu_pkg::HALT, 8'h00, 16'h0000);
    expect_write(10'd48, 16'(a + b));
    expect_write(10'd49, 16'(a - c));
    run_program();
    check_writes();
  endtask

  task automatic load_and_store_back();
    logic [15:0] v;
    v = 16'($urandom);
    begin_program();
    memory.mem[52] = v;
    emit(cpu_pkg::RAM2REG, 8'h06, 16'd52);
    emit(cpu_pkg::REG2RAM, 8'h06, 16'd53);
    emit(cpu_pkg::HALT, 8'h00, 16'h0000);
    expect_write(10'd53, v);
    run_program();
    check_writes();
  endtask

  task automatic jump_over_store();
    begin_program();
    emit(cpu_pkg::NUM2REG, 8'h02, 16'h1234);
    emit(cpu_pkg::JMP, 8'h00, 16'd8);
    emit(cpu_pkg::REG2RAM, 8'h02, 16'd45);  // skipped
    emit(cpu_pkg::HALT, 8'h00, 16'h0000);
    emit(cpu_pkg::REG2RAM, 8'h02, 16'd46);  // jump target
    emit(cpu_pkg::HALT, 8'h00, 16'h0000);
    expect_write(10'd46, 16'h1234);
    run_program();
    check_writes();
  endtask

  task automatic page_allocation();
    logic [15:0] laddr [5];
    logic [3:0]  ppage [5];
    logic [15:0] v;
    laddr = '{{10'd5, 6'd3}, {10'd2, 6'd10}, {10'd5, 6'd20}, {10'd9, 6'd63}, {10'd2, 6'd1}};
    ppage = '{4'd1, 4'd2, 4'd1, 4'd3, 4'd2};  // pages handed out in order
    begin_program();
    foreach (laddr[i]) begin
      v = 16'($urandom);
      emit(cpu_pkg::NUM2REG, 8'h07, v);
      emit(cpu_pkg::REG2RAM, 8'h07, laddr[i]);
      expect_write({ppage[i], laddr[i][5:0]}, v);
    end
    emit(cpu_pkg::HALT, 8'h00, 16'h0000);
    run_program();
    check_writes();
  endtask

  task automatic page_exhaustion_fault();
    logic [15:0] v;
    v = 16'($urandom);
    begin_program();
    emit(cpu_pkg::NUM2REG, 8'h01, v);
    for (int p = 1; p <= 16; p++) begin
      emit(cpu_pkg::REG2RAM, 8'h01, {10'(p), 6'(p)});
      if (p < 16) begin
        expect_write({4'(p), 6'(p)}, v);  // 16th page has no room
      end
    end
    emit(cpu_pkg::HALT, 8'h00, 16'h0000);
    run_program();
    check_writes();
    check_value("fault", 1, fault);
    repeat (20) begin
      @(negedge clka);
      assert (!bus_o.cyc) else stop_with_failure("a bus cycle started after the fault");
    end
  endtask

  always @(negedge clka) begin
    assert (!memory.unstable) else
      stop_with_failure("Wishbone adr, we or dat changed while stb waited for ack");
  end

  initial begin
    repeat (NUM_TESTS * 2000) @(posedge clka);
    stop_with_failure("watchdog timeout, the tests did not finish in time");
  end

  initial begin
    void'($urandom(32'h2cb7dd94));
    clka = 1'b0;
    rst  = 1'b0;
    basic_store_and_halt();
    wrapped_arithmetic();
    load_and_store_back();
    jump_over_store();
    page_allocation();
    page_exhaustion_fault();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: tb_wb_memory.sv
`include "cpu_macros.svh"

module tb_wb_memory (
  input  logic             clka,
  input  cpu_pkg::wb_m2s_t m2s,
  output cpu_pkg::wb_s2m_t s2m
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS = 1 << `CPU_PADDR_W;

  logic [`CPU_DATA_W-1:0]  mem [MEM_WORDS];
  logic [`CPU_PADDR_W-1:0] log_adr [$];  // one entry per write
  logic [`CPU_DATA_W-1:0]  log_dat [$];
  int unsigned             wait_left;    // wait states before the next ack
  logic                    held;         // previous edge saw stb waiting
  logic                    unstable;     // sticky, request moved during a wait
  cpu_pkg::wb_m2s_t        held_req;

  initial begin
    s2m       = '0;
    held      = 1'b0;
    unstable  = 1'b0;
    wait_left = 0;
  end

  // pattern over the whole address, log emptied
  task automatic reset_contents();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 16'(i * 16'h03b5) ^ 16'hc0de;
    end
    log_adr.delete();
    log_dat.delete();
  endtask

  always @(posedge clka) begin
    if (m2s.cyc && m2s.stb) begin
      if (held && (m2s.adr !== held_req.adr || m2s.we !== held_req.we ||
                   m2s.dat !== held_req.dat)) begin
        unstable <= 1'b1;
      end
      held     <= !s2m.ack;  // ack seen, cycle ends here
      held_req <= m2s;
    end else begin
      held <= 1'b0;
    end
    if (s2m.ack) begin
      s2m.ack   <= 1'b0;
      wait_left <= $urandom % 4;
    end else if (m2s.cyc && m2s.stb) begin
      if (wait_left == 0) begin
        s2m.ack <= 1'b1;
        s2m.dat <= mem[m2s.adr];
        if (m2s.we) begin
          mem[m2s.adr] <= m2s.dat;
          log_adr.push_back(m2s.adr);
          log_dat.push_back(m2s.dat);
        end
      end else begin
        wait_left <= wait_left - 1;
      end
    end
  end

endmodule

// File: cpu_top.sv
module cpu_top (
  input  logic             clka,
  input  logic             rst,
  output cpu_pkg::wb_m2s_t bus_o,
  input  cpu_pkg::wb_s2m_t bus_i,
  output logic             halted,
  output logic             fault
);

  cpu_pkg::mmu_req_t mmu_req;
  cpu_pkg::mmu_rsp_t mmu_rsp;
  cpu_pkg::mem_req_t mem_req;
  cpu_pkg::mem_rsp_t mem_rsp;

  cpu_sequencer u_seq (
    .clka    (clka),
    .rst     (rst),
    .mmu_req (mmu_req),
    .mmu_rsp (mmu_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .halted  (halted),
    .fault   (fault)
  );

  // logical to physical translation
  page_mmu u_mmu (
    .clka (clka),
    .rst  (rst),
    .req  (mmu_req),
    .rsp  (mmu_rsp)
  );

  // single Wishbone classic port to memory
  wb_mem_master u_bus (
    .clka  (clka),
    .rst   (rst),
    .req   (mem_req),
    .rsp   (mem_rsp),
    .bus_o (bus_o),
    .bus_i (bus_i)
  );

endmodule

// File: cpu_sequencer.sv
`include "cpu_macros.svh"

module cpu_sequencer (
  input  logic              clka,
  input  logic              rst,
  output cpu_pkg::mmu_req_t mmu_req,
  input  cpu_pkg::mmu_rsp_t mmu_rsp,
  output cpu_pkg::mem_req_t mem_req,
  input  cpu_pkg::mem_rsp_t mem_rsp,
  output logic              halted,
  output logic              fault
);

  cpu_pkg::seq_state_e state;
  cpu_pkg::opcode_e    op;

  logic [`CPU_LADDR_W-1:0]  pc;
  logic [`CPU_REG_BITS-1:0] reg_idx;  // low bits of the register byte
  logic [`CPU_DATA_W-1:0]   operand;  // value or address word
  logic [`CPU_DATA_W-1:0]   regs [`CPU_REG_NUM];

  logic                    mmu_wait;  // translation in flight
  logic                    mem_wait;  // bus access in flight
  logic [`CPU_LADDR_W-1:0] access_addr;

  assign halted = (state == cpu_pkg::HALTED);

  // logical address of the access owned by the current state
  always_comb begin
    case (state)
      cpu_pkg::FETCH1: access_addr = pc;
      cpu_pkg::FETCH2: access_addr = pc + 1'b1;
      default:         access_addr = operand;
    endcase
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state         <= cpu_pkg::FETCH1;
      pc            <= '0;
      fault         <= 1'b0;
      mmu_wait      <= 1'b0;
      mem_wait      <= 1'b0;
      mmu_req.valid <= 1'b0;
      mem_req.valid <= 1'b0;
      for (int i = 0; i < `CPU_REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else begin
      mmu_req.valid <= 1'b0;
      mem_req.valid <= 1'b0;
      case (state)
        cpu_pkg::FETCH1, cpu_pkg::FETCH2, cpu_pkg::LOAD, cpu_pkg::STORE: begin
          if (mem_wait) begin
            if (mem_rsp.done) begin
              mem_wait <= 1'b0;
              case (state)
                cpu_pkg::FETCH1: begin
                  op      <= cpu_pkg::opcode_e'(mem_rsp.dat[15:8]);
                  reg_idx <= mem_rsp.dat[`CPU_REG_BITS-1:0];
                  state   <= cpu_pkg::FETCH2;
                end
                cpu_pkg::FETCH2: begin
                  operand <= mem_rsp.dat;
                  state   <= cpu_pkg::DECODE;
                end
                cpu_pkg::LOAD: begin
                  regs[reg_idx] <= mem_rsp.dat;
                  state         <= cpu_pkg::FETCH1;
                end
                default: begin
                  state <= cpu_pkg::FETCH1;  // store finished
                end
              endcase
            end
          end else if (mmu_wait) begin
            if (mmu_rsp.done) begin
              mmu_wait <= 1'b0;
              if (mmu_rsp.fault) begin
                fault <= 1'b1;  // no bus cycle after a fault
                state <= cpu_pkg::HALTED;
              end else begin
                mem_req.valid <= 1'b1;
                mem_req.we    <= (state == cpu_pkg::STORE);
                mem_req.adr   <= mmu_rsp.paddr;
                mem_req.dat   <= regs[reg_idx];
                mem_wait      <= 1'b1;
              end
            end
          end else begin
            mmu_req.valid <= 1'b1;  // start the translation
            mmu_req.laddr <= access_addr;
            mmu_wait      <= 1'b1;
          end
        end

        cpu_pkg::DECODE: begin
          pc    <= pc + 2'd2;
          state <= cpu_pkg::FETCH1;
          case (op)
            cpu_pkg::JMP: begin
              pc <= operand;
            end
            cpu_pkg::NUM2REG: begin
              regs[reg_idx] <= operand;
            end
            cpu_pkg::REG_PLUS: begin
              regs[reg_idx] <= regs[reg_idx] + operand;  // wraps at 16 bits
            end
            cpu_pkg::REG_MINUS: begin
              regs[reg_idx] <= regs[reg_idx] - operand;
            end
            cpu_pkg::RAM2REG: begin
              state <= cpu_pkg::LOAD;
            end
            cpu_pkg::REG2RAM: begin
              state <= cpu_pkg::STORE;
            end
            cpu_pkg::HALT: begin
              state <= cpu_pkg::HALTED;
            end
            default: begin
              // unknown opcode, just move on
            end
          endcase
        end

        cpu_pkg::HALTED: begin
          state <= cpu_pkg::HALTED;  // only reset leaves
        end

        default: begin
          state <= cpu_pkg::HALTED;
        end
      endcase
    end
  end

endmodule

// File: wb_mem_master.sv
module wb_mem_master (
  input  logic              clka,
  input  logic              rst,
  input  cpu_pkg::mem_req_t req,
  output cpu_pkg::mem_rsp_t rsp,
  output cpu_pkg::wb_m2s_t  bus_o,
  input  cpu_pkg::wb_s2m_t  bus_i
);

  // one access at a time, cyc high means busy
  always_ff @(posedge clka) begin
    if (!rst) begin
      bus_o.cyc <= 1'b0;
      bus_o.stb <= 1'b0;
      bus_o.we  <= 1'b0;
      rsp.done  <= 1'b0;
    end else begin
      rsp.done <= 1'b0;
      if (bus_o.cyc) begin
        if (bus_i.ack) begin
          bus_o.cyc <= 1'b0;  // end of cycle, no back to back
          bus_o.stb <= 1'b0;
          bus_o.we  <= 1'b0;
          rsp.done  <= 1'b1;
          rsp.dat   <= bus_i.dat;  // read data valid with ack
        end
      end else if (req.valid) begin
        bus_o.cyc <= 1'b1;
        bus_o.stb <= 1'b1;
        bus_o.we  <= req.we;
        bus_o.adr <= req.adr;  // held until ack
        bus_o.dat <= req.dat;
      end
    end
  end

endmodule

// File: page_mmu.sv
`include "cpu_macros.svh"

module page_mmu (
  input  logic              clka,
  input  logic              rst,
  input  cpu_pkg::mmu_req_t req,
  output cpu_pkg::mmu_rsp_t rsp
);

  localparam int PAGES = 1 << `CPU_PPAGE_BITS;

  logic [`CPU_PPAGE_BITS-1:0] next_page [PAGES];  // successor in the chain
  logic [`CPU_LPAGE_BITS-1:0] lpage [PAGES];      // owner logical page, 0 is free

  logic [`CPU_LPAGE_BITS-1:0] cache_lpage;  // last translation
  logic [`CPU_PPAGE_BITS-1:0] cache_ppage;
  logic [`CPU_PPAGE_BITS:0]   alloc_idx;    // extra bit flags the end of memory
  logic [`CPU_PPAGE_BITS:0]   scan_idx;
  logic [`CPU_PPAGE_BITS-1:0] chain_end;
  logic [`CPU_PPAGE_BITS-1:0] walk_page;

  logic [`CPU_LPAGE_BITS-1:0] want_lpage;  // latched request
  logic [`CPU_PAGE_BITS-1:0]  want_off;

  logic [`CPU_LPAGE_BITS-1:0] req_lpage;
  logic [`CPU_PAGE_BITS-1:0]  req_off;
  logic [`CPU_PPAGE_BITS-1:0] scan_page;

  cpu_pkg::mmu_state_e state;

  assign req_lpage = req.laddr[`CPU_LADDR_W-1:`CPU_PAGE_BITS];
  assign req_off   = req.laddr[`CPU_PAGE_BITS-1:0];
  assign scan_page = scan_idx[`CPU_PPAGE_BITS-1:0];

  always_ff @(posedge clka) begin
    if (!rst) begin
      state        <= cpu_pkg::IDLE;
      rsp.done     <= 1'b0;
      rsp.fault    <= 1'b0;
      cache_lpage  <= '0;
      cache_ppage  <= '0;
      alloc_idx    <= 1;  // page 0 is never free
      chain_end    <= '0;
      next_page[0] <= '0;  // page 0 alone, linked to itself
      for (int i = 0; i < PAGES; i++) begin
        lpage[i] <= '0;
      end
    end else begin
      rsp.done  <= 1'b0;
      rsp.fault <= 1'b0;
      case (state)
        cpu_pkg::IDLE: begin
          if (req.valid) begin
            want_lpage <= req_lpage;
            want_off   <= req_off;
            if (req_lpage == cache_lpage) begin
              rsp.done  <= 1'b1;  // cached hit
              rsp.paddr <= {cache_ppage, req_off};
            end else begin
              walk_page <= '0;  // chain always starts at page 0
              state     <= cpu_pkg::SEARCH;
            end
          end
        end

        cpu_pkg::SEARCH: begin
          if (lpage[walk_page] == want_lpage) begin
            state <= cpu_pkg::FOUND;
          end else if (walk_page == chain_end) begin
            scan_idx <= alloc_idx;  // not in chain, need a new page
            state    <= cpu_pkg::ALLOC;
          end else begin
            walk_page <= next_page[walk_page];
          end
        end

        cpu_pkg::ALLOC: begin
          if (scan_idx[`CPU_PPAGE_BITS]) begin
            rsp.done  <= 1'b1;  // out of pages
            rsp.fault <= 1'b1;
            state     <= cpu_pkg::IDLE;
          end else if (lpage[scan_page] == '0) begin
            next_page[chain_end] <= scan_page;  // append to chain
            next_page[scan_page] <= scan_page;
            lpage[scan_page]     <= want_lpage;
            chain_end            <= scan_page;
            alloc_idx            <= scan_idx + 1'b1;
            walk_page            <= scan_page;
            state                <= cpu_pkg::FOUND;
          end else begin
            scan_idx <= scan_idx + 1'b1;
          end
        end

        cpu_pkg::FOUND: begin
          rsp.done    <= 1'b1;
          rsp.paddr   <= {walk_page, want_off};
          cache_lpage <= want_lpage;
          cache_ppage <= walk_page;
          state       <= cpu_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// File: cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

  typedef enum logic [7:0] {
    JMP       = 8'd1,
    RAM2REG   = 8'd2,
    REG2RAM   = 8'd3,
    NUM2REG   = 8'd4,
    REG_PLUS  = 8'd5,
    REG_MINUS = 8'd6,
    HALT      = 8'd17
  } opcode_e;

  typedef enum logic [2:0] {
    FETCH1,  // opcode and register word
    FETCH2,  // value or address word
    DECODE,
    LOAD,
    STORE,
    HALTED
  } seq_state_e;

  typedef enum logic [1:0] {
    IDLE,
    SEARCH,  // chain walk
    ALLOC,   // free page scan
    FOUND
  } mmu_state_e;

  typedef struct packed {
    logic                    valid;
    logic [`CPU_LADDR_W-1:0] laddr;
  } mmu_req_t;

  typedef struct packed {
    logic                    done;
    logic [`CPU_PADDR_W-1:0] paddr;
    logic                    fault;
  } mmu_rsp_t;

  typedef struct packed {
    logic                    valid;
    logic                    we;
    logic [`CPU_PADDR_W-1:0] adr;
    logic [`CPU_DATA_W-1:0]  dat;
  } mem_req_t;

  typedef struct packed {
    logic                   done;
    logic [`CPU_DATA_W-1:0] dat;
  } mem_rsp_t;

  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`CPU_PADDR_W-1:0] adr;
    logic [`CPU_DATA_W-1:0]  dat;
  } wb_m2s_t;

  typedef struct packed {
    logic                   ack;
    logic [`CPU_DATA_W-1:0] dat;
  } wb_s2m_t;

endpackage

// File: cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// word and register width
`define CPU_DATA_W 16

// physical word address, 1024 words
`define CPU_PADDR_W 10

// logical address seen by the program
`define CPU_LADDR_W 16

// 64 words per page
`define CPU_PAGE_BITS 6

// 16 physical pages
`define CPU_PPAGE_BITS 4

// logical page index, upper bits of laddr
`define CPU_LPAGE_BITS 10

// register file
`define CPU_REG_NUM 16
`define CPU_REG_BITS 4

`endif
